/* include/cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// word and bus width
`define CPU_DATA_W 32

// register file addressing
`define CPU_REG_AW 5
`define CPU_REG_SP 31 // stack pointer lives in the top register

// architectural reset values
`define CPU_RESET_PC 32'h0000_0000
`define CPU_RESET_SP 32'h0000_1000 // stack grows down from here

`endif

/* hw/cpu_pkg.sv */
`default_nettype none

`include "cpu_defines.svh"

package cpu_pkg;

  typedef enum logic [3:0] {
    fetch_ir = 4'h0,
    eval_ir  = 4'h1,
    fault    = 4'h4
  } state_e;

  // only register mode executes, the rest are named so they can fault
  typedef enum logic [2:0] {
    mode_reg    = 3'h0,
    mode_regind = 3'h1,
    mode_imm    = 3'h2,
    mode_dir    = 3'h4
  } mode_e;

  typedef enum logic [7:0] {
    op_nop      = 8'h00,
    op_cmp      = 8'h02,
    op_inc      = 8'h03,
    op_dec      = 8'h04,
    op_push     = 8'h05,
    op_pop      = 8'h06,
    op_mov      = 8'h07,
    op_com      = 8'h08,
    op_neg      = 8'h09,
    op_alu_base = 8'h20, // low 3 bits pick the alu function
    op_int_base = 8'h30  // 0x31..0x35
  } opcode_e;

  typedef enum logic [2:0] {
    alu_and  = 3'h0,
    alu_or   = 3'h1,
    alu_add  = 3'h2,
    alu_sub  = 3'h3,
    alu_xor  = 3'h4,
    alu_shl  = 3'h5,
    alu_shr  = 3'h6,
    alu_pass = 3'h7
  } alu_func_e;

  typedef enum logic [2:0] {
    int_none = 3'h0,
    int_mulu = 3'h1,
    int_muls = 3'h2,
    int_divu = 3'h4,
    int_divs = 3'h5,
    int_rem  = 3'h6
  } int_func_e;

  typedef enum logic [1:0] {alu2_rb, alu2_one, alu2_four} alu2_sel_e;
  typedef enum logic [2:0] {reg_alu, reg_mdr, reg_neg, reg_com, reg_rb} reg_src_e;
  typedef enum logic [1:0] {mdr_hold, mdr_bus, mdr_rb, mdr_int} mdr_src_e;
  typedef enum logic [1:0] {mar_hold, mar_alu, mar_sp} mar_src_e;

  typedef struct packed {
    logic                   ir_write;
    logic                   ccr_write;
    alu_func_e              alu_func;
    alu2_sel_e              alu2_sel;
    int_func_e              int_func;
    reg_src_e               reg_src;
    logic [`CPU_REG_AW-1:0] reg_read_addr1;
    logic [`CPU_REG_AW-1:0] reg_read_addr2;
    logic [`CPU_REG_AW-1:0] reg_write_addr;
    logic                   reg_write;
    mdr_src_e               mdr_src;
    mar_src_e               mar_src;
    logic                   pc_inc;
    logic                   addr_from_pc; // bus address from pc, else mar path
  } ctrl_word_t;

endpackage

`default_nettype wire

/* hw/cpu_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module cpu_regfile (
  input  wire                    clock,
  input  wire                    reset_n,
  input  wire  [`CPU_REG_AW-1:0] read_addr1,
  input  wire  [`CPU_REG_AW-1:0] read_addr2,
  input  wire  [`CPU_REG_AW-1:0] write_addr,
  input  wire                    write_en,
  input  wire  [`CPU_DATA_W-1:0] write_data,
  output logic [`CPU_DATA_W-1:0] read_data1,
  output logic [`CPU_DATA_W-1:0] read_data2
);

  logic [`CPU_DATA_W-1:0] regs [2**`CPU_REG_AW];

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < 2**`CPU_REG_AW; i++) begin
        regs[i] <= (i == `CPU_REG_SP) ? `CPU_RESET_SP : '0;
      end
    end else if (write_en) begin
      regs[write_addr] <= write_data;
    end
  end

  assign read_data1 = regs[read_addr1]; // combinational reads
  assign read_data2 = regs[read_addr2];

endmodule

`default_nettype wire

/* hw/cpu_alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module cpu_alu (
  input  wire  [`CPU_DATA_W-1:0] a,
  input  wire  [`CPU_DATA_W-1:0] b,
  input  wire  cpu_pkg::alu_func_e alu_func,
  input  wire  cpu_pkg::int_func_e int_func,
  output logic [`CPU_DATA_W-1:0] result,
  output logic [3:0]             flags,      // n z c v
  output logic [`CPU_DATA_W-1:0] int_result
);

  localparam int W = `CPU_DATA_W;

  logic [W:0]          sum;
  logic [W:0]          diff;
  logic signed [W-1:0] quot_s;
  logic                carry;
  logic                ovf;

  assign sum    = {1'b0, a} + {1'b0, b};
  assign diff   = {1'b0, a} - {1'b0, b}; // top bit is the borrow
  assign quot_s = $signed(a) / $signed(b);

  always_comb begin
    carry = 1'b0;
    ovf   = 1'b0;
    case (alu_func)
      cpu_pkg::alu_add: begin
        result = sum[W-1:0];
        carry  = sum[W];
        ovf    = (a[W-1] == b[W-1]) && (sum[W-1] != a[W-1]);
      end
      cpu_pkg::alu_sub: begin
        result = diff[W-1:0];
        carry  = diff[W];
        ovf    = (a[W-1] != b[W-1]) && (diff[W-1] != a[W-1]);
      end
      cpu_pkg::alu_and: result = a & b;
      cpu_pkg::alu_or:  result = a | b;
      cpu_pkg::alu_xor: result = a ^ b;
      cpu_pkg::alu_shl: result = a << b[$clog2(W)-1:0];
      cpu_pkg::alu_shr: result = a >> b[$clog2(W)-1:0]; // logical
      default:          result = b;                     // pass
    endcase
  end

  assign flags = {result[W-1], (result == '0), carry, ovf};

  always_comb begin
    case (int_func)
      cpu_pkg::int_mulu, cpu_pkg::int_muls: int_result = a * b; // low word ignores sign
      cpu_pkg::int_divu: int_result = (b == '0) ? '1 : a / b;
      cpu_pkg::int_divs: int_result = (b == '0) ? '1 : quot_s;
      cpu_pkg::int_rem:  int_result = (b == '0) ? a : a % b;
      default:           int_result = '0;
    endcase
  end

endmodule

`default_nettype wire

/* hw/cpu_control.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module cpu_control (
  input  wire                    clock,
  input  wire                    reset_n,
  input  wire  [`CPU_DATA_W-1:0] ir,
  input  wire  [3:0]             ccr,       // n z c v from datapath
  input  wire                    bus_wait,
  output cpu_pkg::ctrl_word_t    ctrl,
  output logic                   bus_read,
  output logic                   bus_write,
  output logic [3:0]             byteenable,
  output logic                   fault
);

  logic [2:0]             ir_mode;
  logic [7:0]             ir_op;
  logic [`CPU_REG_AW-1:0] ir_ra;
  logic [`CPU_REG_AW-1:0] ir_rb;
  logic [`CPU_REG_AW-1:0] ir_rc;
  cpu_pkg::state_e        state;
  cpu_pkg::state_e        state_next;
  logic [2:0]             seq;
  logic [2:0]             seq_next;
  cpu_pkg::int_func_e     int_sel;

  assign ir_mode = ir[31:29];
  assign ir_op   = ir[28:21];
  assign ir_ra   = ir[20:16];
  assign ir_rb   = ir[15:11];
  assign ir_rc   = ir[10:6];

  assign byteenable = 4'b1111; // word accesses only
  assign fault      = (state == cpu_pkg::fault);

  // IR clears to a nop, so the first state after reset is an idle eval step
  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      state <= cpu_pkg::eval_ir;
      seq   <= '0;
    end else begin
      state <= state_next;
      seq   <= seq_next;
    end
  end

  always_comb begin
    case (ir_op[3:0])
      4'h1: int_sel = cpu_pkg::int_mulu;
      4'h2: int_sel = cpu_pkg::int_muls;
      4'h3: int_sel = cpu_pkg::int_divu;
      4'h4: int_sel = cpu_pkg::int_divs;
      4'h5: int_sel = cpu_pkg::int_rem;
      default: int_sel = cpu_pkg::int_none;
    endcase
  end

  always_comb begin
    state_next          = state;
    seq_next            = seq;
    bus_read            = 1'b0;
    bus_write           = 1'b0;
    ctrl.ir_write       = 1'b0;
    ctrl.ccr_write      = 1'b0;
    ctrl.alu_func       = cpu_pkg::alu_add;
    ctrl.alu2_sel       = cpu_pkg::alu2_rb;
    ctrl.int_func       = int_sel;
    ctrl.reg_src        = cpu_pkg::reg_alu;
    ctrl.reg_read_addr1 = ir_ra;
    ctrl.reg_read_addr2 = ir_rb;
    ctrl.reg_write_addr = ir_ra;
    ctrl.reg_write      = 1'b0;
    ctrl.mdr_src        = cpu_pkg::mdr_hold;
    ctrl.mar_src        = cpu_pkg::mar_hold;
    ctrl.pc_inc         = 1'b0;
    ctrl.addr_from_pc   = 1'b0;
    case (state)
      cpu_pkg::fetch_ir: begin
        ctrl.addr_from_pc = 1'b1;
        case (seq)
          3'd0: begin
            bus_read = 1'b1;
            if (!bus_wait) begin
              seq_next = 3'd1;
            end
          end
          3'd1: begin
            bus_read      = 1'b1; // data cycle
            ctrl.ir_write = 1'b1;
            seq_next      = 3'd2;
          end
          3'd2: begin
            ctrl.pc_inc = 1'b1;
            seq_next    = 3'd0;
            state_next  = cpu_pkg::eval_ir;
          end
          default: state_next = cpu_pkg::fault;
        endcase
      end
      cpu_pkg::eval_ir: begin
        if (ir_mode != cpu_pkg::mode_reg) begin
          state_next = cpu_pkg::fault;
        end else if ({ir_op[7:4], 4'h0} == cpu_pkg::op_alu_base) begin
          ctrl.alu_func       = cpu_pkg::alu_func_e'(ir_op[2:0]);
          ctrl.reg_read_addr1 = ir_rb; // rA <= rB op rC
          ctrl.reg_read_addr2 = ir_rc;
          if (seq == 3'd0) begin
            seq_next = 3'd1; // let the alu settle
          end else begin
            ctrl.reg_write = 1'b1;
            seq_next       = 3'd0;
            state_next     = cpu_pkg::fetch_ir;
          end
        end else if ({ir_op[7:4], 4'h0} == cpu_pkg::op_int_base) begin
          ctrl.reg_read_addr1 = ir_rb;
          ctrl.reg_read_addr2 = ir_rc;
          if (int_sel == cpu_pkg::int_none) begin
            state_next = cpu_pkg::fault;
          end else begin
            case (seq)
              3'd6: begin
                ctrl.mdr_src = cpu_pkg::mdr_int; // result has settled
                seq_next     = 3'd7;
              end
              3'd7: begin
                ctrl.reg_src   = cpu_pkg::reg_mdr;
                ctrl.reg_write = 1'b1;
                seq_next       = 3'd0;
                state_next     = cpu_pkg::fetch_ir;
              end
              default: seq_next = seq + 3'd1;
            endcase
          end
        end else begin
          case (ir_op)
            cpu_pkg::op_nop: state_next = cpu_pkg::fetch_ir;
            cpu_pkg::op_cmp: begin
              ctrl.alu_func  = cpu_pkg::alu_sub; // flags of rA - rB
              ctrl.ccr_write = 1'b1;
              state_next     = cpu_pkg::fetch_ir;
            end
            cpu_pkg::op_inc, cpu_pkg::op_dec: begin
              ctrl.alu_func  = (ir_op == cpu_pkg::op_dec) ? cpu_pkg::alu_sub : cpu_pkg::alu_add;
              ctrl.alu2_sel  = cpu_pkg::alu2_one;
              ctrl.reg_write = 1'b1;
              state_next     = cpu_pkg::fetch_ir;
            end
            cpu_pkg::op_push: begin
              ctrl.reg_read_addr1 = `CPU_REG_SP;
              ctrl.alu_func       = cpu_pkg::alu_sub;
              ctrl.alu2_sel       = cpu_pkg::alu2_four;
              ctrl.reg_read_addr2 = ir_ra;
              case (seq)
                3'd0: begin
                  ctrl.mar_src = cpu_pkg::mar_alu; // mar <= sp - 4
                  ctrl.mdr_src = cpu_pkg::mdr_rb;  // mdr <= rA
                  seq_next     = 3'd1;
                end
                3'd1: begin
                  bus_write = 1'b1;
                  if (!bus_wait) begin
                    seq_next = 3'd2;
                  end
                end
                default: begin
                  ctrl.reg_write_addr = `CPU_REG_SP; // sp <= sp - 4
                  ctrl.reg_write      = 1'b1;
                  seq_next            = 3'd0;
                  state_next          = cpu_pkg::fetch_ir;
                end
              endcase
            end
            cpu_pkg::op_pop: begin
              ctrl.reg_read_addr1 = `CPU_REG_SP;
              ctrl.alu2_sel       = cpu_pkg::alu2_four;
              case (seq)
                3'd0: begin
                  bus_read     = 1'b1;
                  ctrl.mar_src = cpu_pkg::mar_sp; // address bypasses mar
                  if (!bus_wait) begin
                    seq_next = 3'd1;
                  end
                end
                3'd1: begin
                  bus_read            = 1'b1;
                  ctrl.mdr_src        = cpu_pkg::mdr_bus;
                  ctrl.reg_write_addr = `CPU_REG_SP; // sp <= sp + 4
                  ctrl.reg_write      = 1'b1;
                  seq_next            = 3'd2;
                end
                default: begin
                  ctrl.reg_src   = cpu_pkg::reg_mdr;
                  ctrl.reg_write = 1'b1;
                  seq_next       = 3'd0;
                  state_next     = cpu_pkg::fetch_ir;
                end
              endcase
            end
            cpu_pkg::op_mov, cpu_pkg::op_com, cpu_pkg::op_neg: begin
              if (ir_op == cpu_pkg::op_mov) begin
                ctrl.reg_src = cpu_pkg::reg_rb;
              end else if (ir_op == cpu_pkg::op_com) begin
                ctrl.reg_src = cpu_pkg::reg_com;
              end else begin
                ctrl.reg_src = cpu_pkg::reg_neg;
              end
              ctrl.reg_write = 1'b1;
              state_next     = cpu_pkg::fetch_ir;
            end
            default: state_next = cpu_pkg::fault;
          endcase
        end
      end
      default: state_next = cpu_pkg::fault; // fault holds until reset
    endcase
  end

endmodule

`default_nettype wire

/* hw/cpu_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module cpu_datapath (
  input  wire                    clock,
  input  wire                    reset_n,
  input  wire cpu_pkg::ctrl_word_t ctrl,
  input  wire  [`CPU_DATA_W-1:0] bus_rdata,
  output logic [`CPU_DATA_W-1:0] ir,
  output logic [3:0]             ccr,
  output logic [`CPU_DATA_W-1:0] bus_addr,
  output logic [`CPU_DATA_W-1:0] bus_wdata
);

  logic [`CPU_DATA_W-1:0] pc;
  logic [`CPU_DATA_W-1:0] mar;
  logic [`CPU_DATA_W-1:0] mdr;
  logic [`CPU_DATA_W-1:0] mar_in;
  logic [`CPU_DATA_W-1:0] read_data1;
  logic [`CPU_DATA_W-1:0] read_data2;
  logic [`CPU_DATA_W-1:0] write_data;
  logic [`CPU_DATA_W-1:0] alu_b;
  logic [`CPU_DATA_W-1:0] alu_result;
  logic [`CPU_DATA_W-1:0] int_result;
  logic [3:0]             flags;

  cpu_regfile u_regfile (
    .clock      (clock),
    .reset_n    (reset_n),
    .read_addr1 (ctrl.reg_read_addr1),
    .read_addr2 (ctrl.reg_read_addr2),
    .write_addr (ctrl.reg_write_addr),
    .write_en   (ctrl.reg_write),
    .write_data (write_data),
    .read_data1 (read_data1),
    .read_data2 (read_data2)
  );

  cpu_alu u_alu (
    .a          (read_data1),
    .b          (alu_b),
    .alu_func   (ctrl.alu_func),
    .int_func   (ctrl.int_func),
    .result     (alu_result),
    .flags      (flags),
    .int_result (int_result)
  );

  always_comb begin
    case (ctrl.alu2_sel)
      cpu_pkg::alu2_one:  alu_b = `CPU_DATA_W'(1);
      cpu_pkg::alu2_four: alu_b = `CPU_DATA_W'(4);
      default:            alu_b = read_data2;
    endcase
  end

  always_comb begin
    case (ctrl.reg_src)
      cpu_pkg::reg_mdr: write_data = mdr;
      cpu_pkg::reg_neg: write_data = -read_data2;
      cpu_pkg::reg_com: write_data = ~read_data2;
      cpu_pkg::reg_rb:  write_data = read_data2;
      default:          write_data = alu_result;
    endcase
  end

  // value mar takes at the next edge, also the bypass for same-cycle requests
  always_comb begin
    case (ctrl.mar_src)
      cpu_pkg::mar_alu: mar_in = alu_result;
      cpu_pkg::mar_sp:  mar_in = read_data1;
      default:          mar_in = mar;
    endcase
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      pc  <= `CPU_RESET_PC;
      ir  <= '0;
      mar <= '0;
      mdr <= '0;
      ccr <= '0;
    end else begin
      if (ctrl.pc_inc) begin
        pc <= pc + `CPU_DATA_W'(4);
      end
      if (ctrl.ir_write) begin
        ir <= bus_rdata;
      end
      mar <= mar_in;
      case (ctrl.mdr_src)
        cpu_pkg::mdr_bus: mdr <= bus_rdata;
        cpu_pkg::mdr_rb:  mdr <= read_data2;
        cpu_pkg::mdr_int: mdr <= int_result;
        default:          mdr <= mdr;
      endcase
      if (ctrl.ccr_write) begin
        ccr <= flags;
      end
    end
  end

  assign bus_addr  = ctrl.addr_from_pc ? pc : mar_in;
  assign bus_wdata = mdr; // only push writes

endmodule

`default_nettype wire

/* hw/cpu_core.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module cpu_core (
  input  wire                    clock,
  input  wire                    reset_n,
  output logic [`CPU_DATA_W-1:0] bus_addr,
  output logic [`CPU_DATA_W-1:0] bus_wdata,
  input  wire  [`CPU_DATA_W-1:0] bus_rdata,
  output logic                   bus_read,
  output logic                   bus_write,
  output logic [3:0]             byteenable,
  input  wire                    bus_wait,
  output logic                   fault
);

  cpu_pkg::ctrl_word_t    ctrl;
  logic [`CPU_DATA_W-1:0] ir;
  logic [3:0]             ccr;

  cpu_control u_control (
    .clock      (clock),
    .reset_n    (reset_n),
    .ir         (ir),
    .ccr        (ccr),
    .bus_wait   (bus_wait),
    .ctrl       (ctrl),
    .bus_read   (bus_read),
    .bus_write  (bus_write),
    .byteenable (byteenable),
    .fault      (fault)
  );

  cpu_datapath u_datapath (
    .clock     (clock),
    .reset_n   (reset_n),
    .ctrl      (ctrl),
    .bus_rdata (bus_rdata),
    .ir        (ir),
    .ccr       (ccr),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata)
  );

endmodule

`default_nettype wire

/* sim/cpu_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module cpu_checker #(
  parameter int EXP_DEPTH = 64
) (
  input  wire                    clock,
  input  wire                    reset_n,
  input  wire  [`CPU_DATA_W-1:0] bus_addr,
  input  wire  [`CPU_DATA_W-1:0] bus_wdata,
  input  wire                    bus_read,
  input  wire                    bus_write,
  input  wire  [3:0]             byteenable,
  input  wire                    bus_wait,
  input  wire                    fault,
  input  logic [31:0]            exp_addr [EXP_DEPTH],
  input  logic [31:0]            exp_data [EXP_DEPTH],
  input  int                     exp_count,
  output int                     write_count,
  output int                     error_count
);

  initial begin
    write_count = 0;
    error_count = 0;
  end

  // a write completes on the edge where bus_wait is low
  always @(posedge clock) begin
    if (reset_n && bus_write && !bus_wait) begin
      if (write_count >= exp_count) begin
        $display("unexpected bus write to %h after all %0d expected writes", bus_addr,
                 exp_count);
        error_count++;
      end else begin
        if (bus_addr !== exp_addr[write_count]) begin
          $display("Mismatch bus_addr: got %h expected %h (write %0d)", bus_addr,
                   exp_addr[write_count], write_count);
          error_count++;
        end
        if (bus_wdata !== exp_data[write_count]) begin
          $display("Mismatch bus_wdata: got %h expected %h (write %0d)", bus_wdata,
                   exp_data[write_count], write_count);
          error_count++;
        end
      end
      if (byteenable !== 4'b1111) begin
        $display("Mismatch byteenable: got %h expected f", byteenable);
        error_count++;
      end
      write_count++;
    end
    if (reset_n && fault && bus_read) begin
      $display("core issued a bus read while in the fault state");
      error_count++;
    end
  end

endmodule

`default_nettype wire

/* sim/cpu_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_properties (
  input wire                      clock,
  input wire                      reset_n,
  input wire                      bus_read,
  input wire                      bus_write,
  input wire                      bus_wait,
  input wire                      fault,
  input wire [2:0]                seq,
  input wire [3:0]                ccr,
  input wire cpu_pkg::ctrl_word_t ctrl
);

  int fail_count = 0;

  assert property (@(posedge clock) disable iff (!reset_n) !(bus_read && bus_wait && bus_write)
                   && !(bus_read && bus_write))
    else begin
      $error("bus_read and bus_write high together");
      fail_count++;
    end

  // a stalled read request in step 0 may not drop
  assert property (@(posedge clock) disable iff (!reset_n)
                   (bus_read && bus_wait && seq == 3'd0) |=> bus_read)
    else begin
      $error("bus_read dropped under bus_wait");
      fail_count++;
    end

  assert property (@(posedge clock) disable iff (!reset_n)
                   (bus_write && bus_wait) |=> bus_write)
    else begin
      $error("bus_write dropped under bus_wait");
      fail_count++;
    end

  assert property (@(posedge clock) disable iff (!reset_n) fault |=> fault)
    else begin
      $error("fault fell without reset");
      fail_count++;
    end

  // ccr only moves after the cmp step that writes it
  assert property (@(posedge clock) disable iff (!reset_n)
                   !ctrl.ccr_write |=> $stable(ccr))
    else begin
      $error("ccr changed without a ccr write");
      fail_count++;
    end

endmodule

bind cpu_control cpu_properties u_properties (
  .clock     (clock),
  .reset_n   (reset_n),
  .bus_read  (bus_read),
  .bus_write (bus_write),
  .bus_wait  (bus_wait),
  .fault     (fault),
  .seq       (seq),
  .ccr       (ccr),
  .ctrl      (ctrl)
);

`default_nettype wire

/* sim/cpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defines.svh"

module cpu_tb;

  localparam int MEM_WORDS = 1024;    // 4 KB
  localparam int EXP_DEPTH = 64;
  localparam int FAULT_TIMEOUT = 20000;
  localparam int QUIET_CYCLES = 200;  // window in which no write may follow the fault

  logic                   clock;
  logic                   reset_n;
  logic [`CPU_DATA_W-1:0] bus_addr;
  logic [`CPU_DATA_W-1:0] bus_wdata;
  logic [`CPU_DATA_W-1:0] bus_rdata;
  logic                   bus_read;
  logic                   bus_write;
  logic [3:0]             byteenable;
  logic                   bus_wait;
  logic                   fault;
  logic [31:0]            mem [MEM_WORDS];
  logic [31:0]            exp_addr [EXP_DEPTH];
  logic [31:0]            exp_data [EXP_DEPTH];
  int                     exp_count;
  int                     write_count;
  int                     check_errors;
  int                     assert_errors;
  int                     tb_errors;
  int                     prog_addr;
  int                     stack_depth;
  int                     cycles;
  logic [31:0]            rng;

  cpu_core u_dut (
    .clock      (clock),
    .reset_n    (reset_n),
    .bus_addr   (bus_addr),
    .bus_wdata  (bus_wdata),
    .bus_rdata  (bus_rdata),
    .bus_read   (bus_read),
    .bus_write  (bus_write),
    .byteenable (byteenable),
    .bus_wait   (bus_wait),
    .fault      (fault)
  );

  cpu_checker #(.EXP_DEPTH(EXP_DEPTH)) u_checker (
    .clock       (clock),
    .reset_n     (reset_n),
    .bus_addr    (bus_addr),
    .bus_wdata   (bus_wdata),
    .bus_read    (bus_read),
    .bus_write   (bus_write),
    .byteenable  (byteenable),
    .bus_wait    (bus_wait),
    .fault       (fault),
    .exp_addr    (exp_addr),
    .exp_data    (exp_data),
    .exp_count   (exp_count),
    .write_count (write_count),
    .error_count (check_errors)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // memory answers with roughly one wait cycle in four
  always @(posedge clock) begin
    rng      <= lcg_next(rng);
    bus_wait <= (rng[17:16] == 2'b00);
    if (bus_read && !bus_wait) begin
      bus_rdata <= mem[bus_addr[11:2]];
    end
    if (bus_write && !bus_wait) begin
      mem[bus_addr[11:2]] <= bus_wdata;
    end
  end

  task automatic put_instr(input logic [7:0] op, input logic [4:0] ra,
                           input logic [4:0] rb, input logic [4:0] rc);
    mem[prog_addr >> 2] = {3'b000, op, ra, rb, rc, 6'b0}; // register mode only
    prog_addr += 4;
  endtask

  task automatic push_reg(input logic [4:0] r);
    put_instr(8'h05, r, 5'd0, 5'd0);
    stack_depth++;
  endtask

  task automatic pop_reg(input logic [4:0] r);
    put_instr(8'h06, r, 5'd0, 5'd0);
    stack_depth--;
  endtask

  task automatic build_program();
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = 32'hdead_0000 ^ (i * 32'h0001_0003); // fill differs for every word
    end
    mem[1022] = 32'h1234_5678; // preloaded stack words at 0xff8 and 0xffc
    mem[1023] = 32'h0000_0007;
    prog_addr   = `CPU_RESET_PC;
    stack_depth = 0;
    put_instr(8'h03, 5'd1, 5'd0, 5'd0);    // r1 = 1
    put_instr(8'h03, 5'd2, 5'd0, 5'd0);
    put_instr(8'h03, 5'd2, 5'd0, 5'd0);    // r2 = 2
    put_instr(8'h25, 5'd4, 5'd1, 5'd2);    // r4 = 1 << 2
    put_instr(8'h23, 5'd31, 5'd31, 5'd4);  // sp down over the preloaded words
    put_instr(8'h23, 5'd31, 5'd31, 5'd4);
    put_instr(8'h06, 5'd5, 5'd0, 5'd0);    // r5, r6 from memory
    put_instr(8'h06, 5'd6, 5'd0, 5'd0);
    push_reg(5'd5);
    pop_reg(5'd7);
    push_reg(5'd7);
    for (int f = 0; f < 8; f++) begin
      put_instr(8'h20 + 8'(f), 5'd8, 5'd5, 5'd6);
      push_reg(5'd8);
    end
    put_instr(8'h07, 5'd11, 5'd5, 5'd0);   // mov
    push_reg(5'd11);
    put_instr(8'h08, 5'd12, 5'd5, 5'd0);   // com
    push_reg(5'd12);
    put_instr(8'h09, 5'd13, 5'd6, 5'd0);   // neg, r13 = -7
    push_reg(5'd13);
    put_instr(8'h04, 5'd14, 5'd0, 5'd0);   // dec from zero
    push_reg(5'd14);
    put_instr(8'h02, 5'd6, 5'd5, 5'd0);    // cmp with borrow and negative result
    push_reg(5'd5);
    put_instr(8'h31, 5'd15, 5'd5, 5'd6);
    push_reg(5'd15);
    put_instr(8'h32, 5'd15, 5'd13, 5'd5);
    push_reg(5'd15);
    put_instr(8'h33, 5'd15, 5'd5, 5'd6);
    push_reg(5'd15);
    put_instr(8'h34, 5'd15, 5'd5, 5'd13);
    push_reg(5'd15);
    put_instr(8'h35, 5'd15, 5'd5, 5'd6);
    push_reg(5'd15);
    put_instr(8'h33, 5'd16, 5'd5, 5'd0);   // divide by zero, r0 is still zero
    push_reg(5'd16);
    put_instr(8'h34, 5'd16, 5'd5, 5'd0);
    push_reg(5'd16);
    put_instr(8'h35, 5'd16, 5'd5, 5'd0);
    push_reg(5'd16);
    while (stack_depth > 0) begin
      pop_reg(5'd10);
    end
    push_reg(5'd31);                       // sp should be back at reset value
    put_instr(8'hff, 5'd0, 5'd0, 5'd0);    // undefined opcode
    push_reg(5'd5);                        // never executed
  endtask

  // instruction-level model of the program, records the expected bus writes
  function automatic int exec_model();
    logic [31:0] r [32];
    logic [31:0] mm [MEM_WORDS];
    logic [31:0] pc;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] tmp;
    logic [7:0]  op;
    logic [4:0]  ra;
    logic        halted;
    int          n;
    int          step;
    for (int i = 0; i < 32; i++) begin
      r[i] = '0;
    end
    for (int i = 0; i < MEM_WORDS; i++) begin
      mm[i] = mem[i];
    end
    r[`CPU_REG_SP] = `CPU_RESET_SP;
    pc     = `CPU_RESET_PC;
    halted = 1'b0;
    n      = 0;
    step   = 0;
    while (!halted && step < 1000) begin
      w  = mm[pc[11:2]];
      pc = pc + 32'd4;
      op = w[28:21];
      ra = w[20:16];
      a  = r[w[15:11]];
      b  = r[w[10:6]];
      step++;
      if (w[31:29] != 3'b000) begin
        halted = 1'b1;
      end else if (op[7:3] == 5'b00100) begin
        case (op[2:0])
          3'd0: r[ra] = a & b;
          3'd1: r[ra] = a | b;
          3'd2: r[ra] = a + b;
          3'd3: r[ra] = a - b;
          3'd4: r[ra] = a ^ b;
          3'd5: r[ra] = a << b[4:0];
          3'd6: r[ra] = a >> b[4:0];
          default: r[ra] = b;
        endcase
      end else begin
        case (op)
          8'h00, 8'h02: ;                    // nop, cmp leave registers alone
          8'h03: r[ra] = r[ra] + 32'd1;
          8'h04: r[ra] = r[ra] - 32'd1;
          8'h05: begin
            tmp = r[ra];
            r[31] = r[31] - 32'd4;
            mm[r[31][11:2]] = tmp;
            exp_addr[n] = r[31];
            exp_data[n] = tmp;
            n++;
          end
          8'h06: begin
            tmp = mm[r[31][11:2]];
            r[31] = r[31] + 32'd4;
            r[ra] = tmp;
          end
          8'h07: r[ra] = a;
          8'h08: r[ra] = ~a;
          8'h09: r[ra] = -a;
          8'h31, 8'h32: r[ra] = a * b;
          8'h33: r[ra] = (b == '0) ? 32'hffff_ffff : a / b;
          8'h34: r[ra] = (b == '0) ? 32'hffff_ffff : 32'($signed(a) / $signed(b));
          8'h35: r[ra] = (b == '0) ? a : a % b;
          default: halted = 1'b1;
        endcase
      end
    end
    return n;
  endfunction

  initial begin
    reset_n   = 1'b0;
    bus_wait  = 1'b0;
    bus_rdata = '0;
    rng       = 32'h2e64;
    tb_errors = 0;
    build_program();
    exp_count = exec_model();
    repeat (3) @(posedge clock);
    reset_n <= 1'b1;
    cycles = 0;
    while (!fault && cycles < FAULT_TIMEOUT) begin
      @(posedge clock);
      cycles++;
    end
    if (!fault) begin
      $display("timeout: fault never went high after %0d cycles", cycles);
      tb_errors++;
    end else begin
      cycles = 0;
      while (cycles < QUIET_CYCLES) begin // writes in this window are flagged by the checker
        @(posedge clock);
        cycles++;
      end
      if (!fault) begin
        $display("fault dropped after it was raised");
        tb_errors++;
      end
    end
    if (write_count != exp_count) begin
      $display("%0d bus writes seen where %0d were expected", write_count, exp_count);
      tb_errors++;
    end
    assert_errors = u_dut.u_control.u_properties.fail_count;
    $display("errors: %0d checker, %0d assertion, %0d testbench, writes seen %0d of %0d",
             check_errors, assert_errors, tb_errors, write_count, exp_count);
    if (check_errors == 0 && assert_errors == 0 && tb_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* cpu_core.f */
+incdir+include
hw/cpu_pkg.sv
hw/cpu_regfile.sv
hw/cpu_alu.sv
hw/cpu_control.sv
hw/cpu_datapath.sv
hw/cpu_core.sv
sim/cpu_checker.sv
sim/cpu_properties.sv
sim/cpu_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the cpu_core testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module cpu_tb -f cpu_core.f \
  || { echo "build failed"; exit 1; }
out=$(./obj_dir/Vcpu_tb)
echo "$out"
echo "$out" | grep -qx "TB PASSED" && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
